// File: source/ltf_xcorr_pkg.sv
package ltf_xcorr_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Sample and lane formats
    ////////////////////////////////////////////////////////////////////////////

    parameter int SAMPLE_W = 16;                    // Real or imaginary part in Q0.15
    parameter int LTF_LEN  = 64;                    // Samples per window
    parameter int TREE_W   = 8;                     // Lane width inside the trees
    parameter int TREE_DEPTH = $clog2(LTF_LEN);     // Adder layers
    parameter int LANE_PAD = SAMPLE_W - TREE_W;     // Zeros below a tree root

    ////////////////////////////////////////////////////////////////////////////
    // Power stage formats
    ////////////////////////////////////////////////////////////////////////////

    // AC - BD and AD + BC need one growth bit
    parameter int COMB_W = SAMPLE_W + 1;

    // Square of a combined term plus one spare bit
    parameter int SQ_W = 2 * COMB_W + 1;

    parameter int ACC_W       = SQ_W + 1;           // Sum of squares after scaling
    parameter int POWER_SHIFT = 5;                  // Q16.18 -> Q11.23
    parameter int OUT_LSB     = 4;                  // Dropped fraction bits
    parameter int POWER_W     = 32;                 // Output Q11.19 (wraps)

    ////////////////////////////////////////////////////////////////////////////
    // LTF reference signs
    ////////////////////////////////////////////////////////////////////////////

    // Bit i set -> reference part i is -1
    // Real and imaginary parts used for the conjugate product
    parameter logic [LTF_LEN-1:0] LTF_SIGN_RE = 64'h4312_33EC_9BE6_2461;
    parameter logic [LTF_LEN-1:0] LTF_SIGN_IM = 64'h1842_7E0F_07C0_DEF3;

    // Common data types
    typedef logic signed [SAMPLE_W-1:0] sample_t;
    typedef logic signed [TREE_W-1:0]   lane_t;
    typedef logic        [POWER_W-1:0]  power_t;

endpackage

// File: source/ltf_sign_mixer.sv
`timescale 1ns/10ps

module ltf_sign_mixer (
    input  logic [ltf_xcorr_pkg::LTF_LEN*ltf_xcorr_pkg::SAMPLE_W-1:0] re_i,  // Flat, sample 0 low
    input  logic [ltf_xcorr_pkg::LTF_LEN*ltf_xcorr_pkg::SAMPLE_W-1:0] im_i,
    output logic [ltf_xcorr_pkg::LTF_LEN*ltf_xcorr_pkg::TREE_W-1:0]   ac_o,  // re * ref_re
    output logic [ltf_xcorr_pkg::LTF_LEN*ltf_xcorr_pkg::TREE_W-1:0]   bd_o,  // im * ref_im
    output logic [ltf_xcorr_pkg::LTF_LEN*ltf_xcorr_pkg::TREE_W-1:0]   ad_o,  // re * ref_im
    output logic [ltf_xcorr_pkg::LTF_LEN*ltf_xcorr_pkg::TREE_W-1:0]   bc_o   // im * ref_re
);

    localparam int SW = ltf_xcorr_pkg::SAMPLE_W;
    localparam int TW = ltf_xcorr_pkg::TREE_W;

    ////////////////////////////////////////////////////////////////////////////
    // Multiply by the +-1 reference, done as a sign flip per sample
    ////////////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < ltf_xcorr_pkg::LTF_LEN; i++) begin : g_sample
        ltf_xcorr_pkg::sample_t re_s;     // Incoming parts
        ltf_xcorr_pkg::sample_t im_s;
        ltf_xcorr_pkg::sample_t re_neg;   // Negated, wraps at -32768
        ltf_xcorr_pkg::sample_t im_neg;
        ltf_xcorr_pkg::sample_t ac_full;  // Full width products
        ltf_xcorr_pkg::sample_t bd_full;
        ltf_xcorr_pkg::sample_t ad_full;
        ltf_xcorr_pkg::sample_t bc_full;

        assign re_s = re_i[i*SW +: SW];
        assign im_s = im_i[i*SW +: SW];

        // 16-bit negation, -(-32768) stays -32768
        assign re_neg = -re_s;
        assign im_neg = -im_s;

        // Real sign drives ac and bc, imaginary sign drives bd and ad
        assign ac_full = ltf_xcorr_pkg::LTF_SIGN_RE[i] ? re_neg : re_s;
        assign bd_full = ltf_xcorr_pkg::LTF_SIGN_IM[i] ? im_neg : im_s;
        assign ad_full = ltf_xcorr_pkg::LTF_SIGN_IM[i] ? re_neg : re_s;
        assign bc_full = ltf_xcorr_pkg::LTF_SIGN_RE[i] ? im_neg : im_s;

        // Keep the top byte of each lane
        assign ac_o[i*TW +: TW] = ac_full[SW-1 -: TW];
        assign bd_o[i*TW +: TW] = bd_full[SW-1 -: TW];
        assign ad_o[i*TW +: TW] = ad_full[SW-1 -: TW];
        assign bc_o[i*TW +: TW] = bc_full[SW-1 -: TW];
    end

endmodule

// File: source/ltf_adder_tree.sv
`timescale 1ns/10ps

module ltf_adder_tree #(
    parameter int N_LEAVES = 64                 // Power of two
) (
    input  logic                                       clk_i,
    input  logic                                       rst_i,
    input  logic [N_LEAVES*ltf_xcorr_pkg::TREE_W-1:0]  leaves_i,  // Flat, leaf 0 low
    output ltf_xcorr_pkg::lane_t                       root_o
);

    localparam int TW      = ltf_xcorr_pkg::TREE_W;
    localparam int DEPTH   = $clog2(N_LEAVES);  // One register per layer
    localparam int N_NODES = 2 * N_LEAVES - 1;  // Leaves plus all sums

    ////////////////////////////////////////////////////////////////////////////
    // Node storage
    ////////////////////////////////////////////////////////////////////////////

    // Layer l starts at 2N - 2N/2^l, the root is the last node
    ltf_xcorr_pkg::lane_t node [N_NODES];

    for (genvar i = 0; i < N_LEAVES; i++) begin : g_leaf
        assign node[i] = leaves_i[i*TW +: TW];
    end

    ////////////////////////////////////////////////////////////////////////////
    // Summation layers
    ////////////////////////////////////////////////////////////////////////////

    for (genvar l = 1; l <= DEPTH; l++) begin : g_layer
        localparam int IN_OFS  = 2 * N_LEAVES - ((2 * N_LEAVES) >> (l - 1));
        localparam int OUT_OFS = 2 * N_LEAVES - ((2 * N_LEAVES) >> l);
        localparam int N_SUMS  = N_LEAVES >> l;

        for (genvar j = 0; j < N_SUMS; j++) begin : g_node
            logic signed [TW:0] sum_q;        // Pair sum, one growth bit

            always_ff @(posedge clk_i) begin
                if (rst_i) begin
                    sum_q <= '0;
                end else begin
                    // Both operands sign extended to 9 bits
                    sum_q <= node[IN_OFS + 2*j] + node[IN_OFS + 2*j + 1];
                end
            end

            // Drop the LSB, i.e. halve so the lane stays 8 bits
            assign node[OUT_OFS + j] = sum_q[TW:1];
        end
    end

    assign root_o = node[N_NODES-1];   // Mean of the leaves, Q6.9 scale at the top

endmodule

// File: source/ltf_power_calc.sv
`timescale 1ns/10ps

module ltf_power_calc (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  ltf_xcorr_pkg::lane_t  ac_i,       // Tree roots
    input  ltf_xcorr_pkg::lane_t  bd_i,
    input  ltf_xcorr_pkg::lane_t  ad_i,
    input  ltf_xcorr_pkg::lane_t  bc_i,
    output ltf_xcorr_pkg::power_t power_o    // |corr|^2, Q11.19
);

    localparam int COMB_W = ltf_xcorr_pkg::COMB_W;
    localparam int SQ_W   = ltf_xcorr_pkg::SQ_W;
    localparam int ACC_W  = ltf_xcorr_pkg::ACC_W;

    // Roots back to 16 bits, low byte zero
    ltf_xcorr_pkg::sample_t ac_pad;
    ltf_xcorr_pkg::sample_t bd_pad;
    ltf_xcorr_pkg::sample_t ad_pad;
    ltf_xcorr_pkg::sample_t bc_pad;

    logic signed [COMB_W-1:0] re_q;           // Q7.9
    logic signed [COMB_W-1:0] im_q;
    logic signed [SQ_W-1:0]   re_sq_q;        // Q15.18
    logic signed [SQ_W-1:0]   im_sq_q;
    logic        [ACC_W-1:0]  acc_q;          // Q11.23 after the shift, wraps

    assign ac_pad = {ac_i, {ltf_xcorr_pkg::LANE_PAD{1'b0}}};
    assign bd_pad = {bd_i, {ltf_xcorr_pkg::LANE_PAD{1'b0}}};
    assign ad_pad = {ad_i, {ltf_xcorr_pkg::LANE_PAD{1'b0}}};
    assign bc_pad = {bc_i, {ltf_xcorr_pkg::LANE_PAD{1'b0}}};

    ////////////////////////////////////////////////////////////////////////////
    // Three registered steps: combine, square, sum and scale
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            re_q    <= '0;
            im_q    <= '0;
            re_sq_q <= '0;
            im_sq_q <= '0;
            acc_q   <= '0;
        end else begin
            re_q    <= ac_pad - bd_pad;                 // Real part of x * conj(ref)
            im_q    <= ad_pad + bc_pad;                 // Imaginary part
            re_sq_q <= re_q * re_q;
            im_sq_q <= im_q * im_q;
            // Overflow above bit 35 is discarded
            acc_q   <= (re_sq_q + im_sq_q) <<< ltf_xcorr_pkg::POWER_SHIFT;
        end
    end

    // Output slice
    assign power_o = acc_q[ltf_xcorr_pkg::OUT_LSB +: ltf_xcorr_pkg::POWER_W];

endmodule

// File: source/ltf_xcorr_top.sv
`timescale 1ns/10ps

module ltf_xcorr_top #(
    parameter int WINDOW_LEN = ltf_xcorr_pkg::LTF_LEN    // Samples per window
) (
    input  logic                                          clk_i,
    input  logic                                          rst_i,
    input  logic [WINDOW_LEN*ltf_xcorr_pkg::SAMPLE_W-1:0] re_i,          // Window, real
    input  logic [WINDOW_LEN*ltf_xcorr_pkg::SAMPLE_W-1:0] im_i,          // Window, imaginary
    output ltf_xcorr_pkg::power_t                         corr_power_o   // 9 cycles later
);

    ////////////////////////////////////////////////////////////////////////////
    // Internal wiring
    ////////////////////////////////////////////////////////////////////////////

    // Product lanes, one per tree
    logic [WINDOW_LEN*ltf_xcorr_pkg::TREE_W-1:0] ac_lanes;
    logic [WINDOW_LEN*ltf_xcorr_pkg::TREE_W-1:0] bd_lanes;
    logic [WINDOW_LEN*ltf_xcorr_pkg::TREE_W-1:0] ad_lanes;
    logic [WINDOW_LEN*ltf_xcorr_pkg::TREE_W-1:0] bc_lanes;

    // Tree roots
    ltf_xcorr_pkg::lane_t root_ac;
    ltf_xcorr_pkg::lane_t root_bd;
    ltf_xcorr_pkg::lane_t root_ad;
    ltf_xcorr_pkg::lane_t root_bc;

    // Sign flip against the LTF reference, no register
    ltf_sign_mixer u_mixer (
        .re_i (re_i),
        .im_i (im_i),
        .ac_o (ac_lanes),
        .bd_o (bd_lanes),
        .ad_o (ad_lanes),
        .bc_o (bc_lanes)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Four summation trees, 6 cycles each
    ////////////////////////////////////////////////////////////////////////////

    ltf_adder_tree #(.N_LEAVES(WINDOW_LEN)) u_tree_ac (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .leaves_i (ac_lanes),
        .root_o   (root_ac)
    );

    ltf_adder_tree #(.N_LEAVES(WINDOW_LEN)) u_tree_bd (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .leaves_i (bd_lanes),
        .root_o   (root_bd)
    );

    ltf_adder_tree #(.N_LEAVES(WINDOW_LEN)) u_tree_ad (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .leaves_i (ad_lanes),
        .root_o   (root_ad)
    );

    ltf_adder_tree #(.N_LEAVES(WINDOW_LEN)) u_tree_bc (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .leaves_i (bc_lanes),
        .root_o   (root_bc)
    );

    // Combine and square, 3 more cycles
    ltf_power_calc u_power (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .ac_i    (root_ac),
        .bd_i    (root_bd),
        .ad_i    (root_ad),
        .bc_i    (root_bc),
        .power_o (corr_power_o)
    );

endmodule

// File: include/tb_ltf_xcorr_model.svh
`ifndef TB_LTF_XCORR_MODEL_SVH
`define TB_LTF_XCORR_MODEL_SVH

// Sign flip with 16-bit wrap, then keep the top lane bits
function automatic ltf_xcorr_pkg::lane_t model_lane(input ltf_xcorr_pkg::sample_t s,
                                                    input logic neg);
    ltf_xcorr_pkg::sample_t v;
    v = neg ? -s : s;
    return v[ltf_xcorr_pkg::SAMPLE_W-1 -: ltf_xcorr_pkg::TREE_W];
endfunction

// Pairwise sums, halved at every layer, done in place
function automatic ltf_xcorr_pkg::lane_t model_tree(
    input ltf_xcorr_pkg::lane_t leaves [ltf_xcorr_pkg::LTF_LEN]);
    ltf_xcorr_pkg::lane_t node [ltf_xcorr_pkg::LTF_LEN];
    logic signed [ltf_xcorr_pkg::TREE_W:0] s;
    node = leaves;
    for (int l = 1; l <= ltf_xcorr_pkg::TREE_DEPTH; l++) begin
        for (int j = 0; j < (ltf_xcorr_pkg::LTF_LEN >> l); j++) begin
            s = node[2*j] + node[2*j+1];
            node[j] = s[ltf_xcorr_pkg::TREE_W:1];
        end
    end
    return node[0];
endfunction

// Pad, combine, square, scale mod 2^36 and slice
function automatic ltf_xcorr_pkg::power_t model_power(input ltf_xcorr_pkg::lane_t ac, bd,
                                                      input ltf_xcorr_pkg::lane_t ad, bc);
    logic signed [ltf_xcorr_pkg::COMB_W-1:0] re;
    logic signed [ltf_xcorr_pkg::COMB_W-1:0] im;
    logic signed [ltf_xcorr_pkg::SQ_W-1:0]   re_sq;
    logic signed [ltf_xcorr_pkg::SQ_W-1:0]   im_sq;
    logic        [ltf_xcorr_pkg::ACC_W-1:0]  acc;
    re    = $signed({ac, {ltf_xcorr_pkg::LANE_PAD{1'b0}}})
          - $signed({bd, {ltf_xcorr_pkg::LANE_PAD{1'b0}}});
    im    = $signed({ad, {ltf_xcorr_pkg::LANE_PAD{1'b0}}})
          + $signed({bc, {ltf_xcorr_pkg::LANE_PAD{1'b0}}});
    re_sq = re * re;
    im_sq = im * im;
    acc   = (re_sq + im_sq) <<< ltf_xcorr_pkg::POWER_SHIFT;
    return acc[ltf_xcorr_pkg::OUT_LSB +: ltf_xcorr_pkg::POWER_W];
endfunction

// Whole window to expected correlation power
function automatic ltf_xcorr_pkg::power_t model_corr(
    input logic [ltf_xcorr_pkg::LTF_LEN*ltf_xcorr_pkg::SAMPLE_W-1:0] re_w,
    input logic [ltf_xcorr_pkg::LTF_LEN*ltf_xcorr_pkg::SAMPLE_W-1:0] im_w);
    ltf_xcorr_pkg::lane_t   ac [ltf_xcorr_pkg::LTF_LEN];
    ltf_xcorr_pkg::lane_t   bd [ltf_xcorr_pkg::LTF_LEN];
    ltf_xcorr_pkg::lane_t   ad [ltf_xcorr_pkg::LTF_LEN];
    ltf_xcorr_pkg::lane_t   bc [ltf_xcorr_pkg::LTF_LEN];
    ltf_xcorr_pkg::sample_t re_s;
    ltf_xcorr_pkg::sample_t im_s;
    for (int i = 0; i < ltf_xcorr_pkg::LTF_LEN; i++) begin
        re_s  = re_w[i*ltf_xcorr_pkg::SAMPLE_W +: ltf_xcorr_pkg::SAMPLE_W];
        im_s  = im_w[i*ltf_xcorr_pkg::SAMPLE_W +: ltf_xcorr_pkg::SAMPLE_W];
        ac[i] = model_lane(re_s, ltf_xcorr_pkg::LTF_SIGN_RE[i]);
        bd[i] = model_lane(im_s, ltf_xcorr_pkg::LTF_SIGN_IM[i]);
        ad[i] = model_lane(re_s, ltf_xcorr_pkg::LTF_SIGN_IM[i]);
        bc[i] = model_lane(im_s, ltf_xcorr_pkg::LTF_SIGN_RE[i]);
    end
    return model_power(model_tree(ac), model_tree(bd), model_tree(ad), model_tree(bc));
endfunction

`endif

// File: tests/tb_ltf_xcorr.sv
`timescale 1ns/10ps

module tb_ltf_xcorr;

    localparam int WIN_BITS   = ltf_xcorr_pkg::LTF_LEN * ltf_xcorr_pkg::SAMPLE_W;
    localparam int LATENCY    = ltf_xcorr_pkg::TREE_DEPTH + 3;  // Trees plus power stage
    localparam int RST_CYCLES = 5;
    localparam int N_RANDOM   = 100;
    // Twice the random stream and five tests of about twenty cycles
    localparam int MAX_CYCLES = 2 * (N_RANDOM + 5 * (LATENCY + 11));

    `include "tb_ltf_xcorr_model.svh"

    logic                  clk;
    logic                  rst;
    logic [WIN_BITS-1:0]   re_win;
    logic [WIN_BITS-1:0]   im_win;
    ltf_xcorr_pkg::power_t corr_power;
    string                 tag_drv;       // Test owning the window on the inputs ("" if unchecked)

    ltf_xcorr_pkg::power_t exp_q [$];     // One entry per clock edge
    string                 tag_q [$];
    logic [31:0] rng_state = 32'h309e;
    int cycle = 0;
    int test_checks;
    int test_errors;
    int total_checks;
    int total_errors;
    int tests_run;
    int tests_failed;

    ltf_xcorr_top #(.WINDOW_LEN(ltf_xcorr_pkg::LTF_LEN)) UUT (
        .clk_i        (clk),
        .rst_i        (rst),
        .re_i         (re_win),
        .im_i         (im_win),
        .corr_power_o (corr_power)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Scoreboard checks each entry nine edges after its push
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin : scoreboard
        ltf_xcorr_pkg::power_t expected;
        if (exp_q.size() == LATENCY) begin
            if (tag_q[0] != "") begin
                test_checks++;
                total_checks++;
                assert (corr_power === exp_q[0]) else begin
                    $display("ERR %s: expected %h, actual %h", tag_q[0], exp_q[0], corr_power);
                    test_errors++;
                    total_errors++;
                end
            end
            void'(exp_q.pop_front());
            void'(tag_q.pop_front());
        end
        if (rst) begin
            // Reset clears the pipeline so windows in flight turn into zeros
            foreach (exp_q[n]) begin
                exp_q[n] = '0;
                tag_q[n] = tag_drv;
            end
            expected = '0;
        end else begin
            expected = model_corr(re_win, im_win);
        end
        exp_q.push_back(expected);
        tag_q.push_back(tag_drv);
    end

    always @(posedge clk) begin : watchdog
        cycle++;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout, run still busy after %0d cycles", MAX_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    function automatic int pending_checks();
        int n;
        n = 0;
        foreach (tag_q[k]) begin
            if (tag_q[k] != "") n++;
        end
        return n;
    endfunction

    task automatic drive_window(input logic [WIN_BITS-1:0] re, input logic [WIN_BITS-1:0] im,
                                input string tag, input logic reset);
        @(posedge clk);
        rst     <= reset;
        re_win  <= re;
        im_win  <= im;
        tag_drv <= tag;
    endtask

    task automatic drive_random(input string tag, input logic reset);
        logic [WIN_BITS-1:0] re;
        logic [WIN_BITS-1:0] im;
        for (int i = 0; i < ltf_xcorr_pkg::LTF_LEN; i++) begin
            rng_state = xorshift32(rng_state);
            re[i*ltf_xcorr_pkg::SAMPLE_W +: ltf_xcorr_pkg::SAMPLE_W] = rng_state[15:0];
            im[i*ltf_xcorr_pkg::SAMPLE_W +: ltf_xcorr_pkg::SAMPLE_W] = rng_state[31:16];
        end
        drive_window(re, im, tag, reset);
    endtask

    task automatic start_test();
        test_checks = 0;
        test_errors = 0;
    endtask

    // Idle inputs and wait until every tagged window has been checked
    task automatic finish_test(input string name);
        drive_window('0, '0, "", 1'b0);
        do @(negedge clk); while (pending_checks() != 0);
        tests_run++;
        if (test_errors != 0 || test_checks == 0) tests_failed++;
        if (test_checks == 0) $display("%s made no checks", name);
        $display("%s: %0d checks, %0d errors", name, test_checks, test_errors);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin : stimulus
        logic [WIN_BITS-1:0] re;
        logic [WIN_BITS-1:0] im;
        rst     = 1'b1;
        re_win  = '0;
        im_win  = '0;
        tag_drv = "";
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;

        start_test();
        repeat (3) drive_window('0, '0, "zero", 1'b0);
        finish_test("zero");

        // Window equal to the reference itself gives the correlation peak
        start_test();
        for (int i = 0; i < ltf_xcorr_pkg::LTF_LEN; i++) begin
            re[i*16 +: 16] = ltf_xcorr_pkg::LTF_SIGN_RE[i] ? -16'sh4000 : 16'sh4000;
            im[i*16 +: 16] = ltf_xcorr_pkg::LTF_SIGN_IM[i] ? -16'sh4000 : 16'sh4000;
        end
        repeat (2) drive_window(re, im, "matched", 1'b0);
        finish_test("matched");

        start_test();
        repeat (N_RANDOM) drive_random("random", 1'b0);
        finish_test("random");

        // Negation of -32768 wraps and full scale squares wrap mod 2^36
        start_test();
        drive_window({ltf_xcorr_pkg::LTF_LEN{16'h8000}}, {ltf_xcorr_pkg::LTF_LEN{16'h8000}},
                     "extremes", 1'b0);
        drive_window({ltf_xcorr_pkg::LTF_LEN{16'h7fff}}, {ltf_xcorr_pkg::LTF_LEN{16'h7fff}},
                     "extremes", 1'b0);
        drive_window({ltf_xcorr_pkg::LTF_LEN{16'h7fff}}, {ltf_xcorr_pkg::LTF_LEN{16'h8000}},
                     "extremes", 1'b0);
        finish_test("extremes");

        start_test();
        repeat (8) drive_random("reset_mid", 1'b0);
        repeat (2) drive_random("reset_mid", 1'b1);     // Data under reset is ignored
        repeat (5) drive_random("reset_mid", 1'b0);
        finish_test("reset_mid");

        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, total_checks, total_errors);
        if (total_errors == 0 && tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: ltf_xcorr.f
+incdir+include
source/ltf_xcorr_pkg.sv
source/ltf_sign_mixer.sv
source/ltf_adder_tree.sv
source/ltf_power_calc.sv
source/ltf_xcorr_top.sv
tests/tb_ltf_xcorr.sv

// File: Bender.yml
package:
  name: ltf_xcorr

sources:
  - files:
      - source/ltf_xcorr_pkg.sv
      - source/ltf_sign_mixer.sv
      - source/ltf_adder_tree.sv
      - source/ltf_power_calc.sv
      - source/ltf_xcorr_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_ltf_xcorr.sv
